//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --timing --assert
TOP := save_state_controller_tb
FILELIST := save_state_controller.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- save_state_controller.f
verilog/save_state_pkg.sv
verilog/load_fifo.sv
verilog/save_state_sequencer.sv
verilog/save_word_unloader.sv
verilog/save_state_controller.sv
test/tb_clock_gen.sv
test/save_state_controller_tb.sv

//--- test/save_state_controller_tb.sv
module save_state_controller_tb
  import save_state_pkg::*;
;

  localparam int save_count = 6;
  localparam int load_entries = 4;
  // word that gets read a second time
  localparam int dup_index = 2;
  localparam int watchdog_cycles = 200 * (save_count + load_entries) + 2000;

  logic clk_74a;
  logic rst_n;
  logic bridge_wr;
  logic bridge_rd;
  bridge_addr_t bridge_addr;
  host_word_t bridge_wr_data;
  host_word_t bridge_rd_data;
  logic bridge_rd_valid;
  logic savestate_load;
  logic savestate_load_ack;
  logic savestate_load_busy;
  logic savestate_load_ok;
  logic savestate_start;
  logic savestate_start_ack;
  logic savestate_start_busy;
  logic savestate_start_ok;
  logic ss_save;
  logic ss_load;
  ss_word_t ss_din;
  ss_word_t ss_dout;
  logic ss_req;
  logic ss_ack;
  logic ss_busy;

  logic [31:0] lfsr_state = 32'h3885bbb7;
  logic failed = 1'b0;
  // phase flags for the timing assertions
  logic in_save = 1'b0;
  logic in_load = 1'b0;
  int ack_count;
  int load_pulses;
  // words the manager model handed over, by index
  ss_word_t save_words[$];
  // packed and swapped words the manager should receive
  ss_word_t load_expect[$];

  tb_clock_gen #(.period(10), .reset_cycles(8)) clock_gen0 (
    .clk_74a(clk_74a),
    .rst_n  (rst_n)
  );

  save_state_controller #(.fifo_addr_bits(4)) dut0 (.*);

  task automatic stop_on_error();
    failed = 1'b1;
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input ss_word_t expected, input ss_word_t actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_low(input string name, input logic actual);
    assert (actual === 1'b0) else begin
      $display("[ERROR] %0t %s expected 0 got %b", $time, name, actual);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  // galois form, one step per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hd0000001;
    end
    return s >> 1;
  endfunction

  task automatic rand_host_word(output host_word_t w);
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic host_word_t reverse_bytes(input host_word_t w);
    host_word_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  // region nibble, word index, half select, byte offset
  function automatic bridge_addr_t word_addr(input int index, input logic high);
    word_index_t idx;
    idx = word_index_t'(index);
    return {bridge_region, idx, high, 2'b00};
  endfunction

  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      ack_count <= 0;
      load_pulses <= 0;
    end else begin
      if (ss_ack) begin
        ack_count <= ack_count + 1;
      end
      if (ss_load) begin
        load_pulses <= load_pulses + 1;
      end
    end
  end

  // strobe one read, count cycles until valid
  task automatic read_half(input int index, input logic high,
                           output host_word_t data, output int latency);
    latency = 0;
    @(negedge clk_74a);
    bridge_rd = 1'b1;
    bridge_addr = word_addr(index, high);
    do begin
      @(negedge clk_74a);
      bridge_rd = 1'b0;
      latency++;
    end while (!bridge_rd_valid);
    data = bridge_rd_data;
  endtask

  task automatic read_word(input int index);
    host_word_t data;
    int latency;
    read_half(index, 1'b0, data, latency);
    check_value("bridge_rd_data", 64'(save_words[index][31:0]), 64'(data));
    // low half is served, so the high half is buffered
    read_half(index, 1'b1, data, latency);
    check_value("bridge_rd_data", 64'(save_words[index][63:32]), 64'(data));
    assert (latency == 1) else begin
      $display("read of word %0d high half took %0d cycles instead of one", index, latency);
      stop_on_error();
    end
  endtask

  task automatic run_save_host();
    int acks_before;
    @(negedge clk_74a);
    savestate_start = 1'b1;
    @(negedge clk_74a);
    savestate_start = 1'b0;
    for (int i = 0; i < save_count; i++) begin
      read_word(i);
      if (i == dup_index) begin
        // let the ack of this word land in the counter
        repeat (3) @(negedge clk_74a);
        acks_before = ack_count;
        read_word(i);
        repeat (3) @(negedge clk_74a);
        check_count("ss_ack count after repeated read", acks_before, ack_count);
      end
    end
  endtask

  // manager model, save side
  task automatic run_save_model();
    host_word_t lo;
    host_word_t hi;
    do @(negedge clk_74a); while (!ss_save);
    ss_busy = 1'b1;
    for (int i = 0; i < save_count; i++) begin
      rand_host_word(lo);
      rand_host_word(hi);
      save_words.push_back({hi, lo});
      ss_din = {hi, lo};
      ss_req = 1'b1;
      do @(negedge clk_74a); while (!ss_ack);
    end
    ss_req = 1'b0;
    ss_busy = 1'b0;
  endtask

  task automatic run_load_host();
    host_word_t lo;
    host_word_t hi;
    for (int e = 0; e < load_entries; e++) begin
      rand_host_word(lo);
      rand_host_word(hi);
      // halves keep their place, bytes reverse within each
      load_expect.push_back({reverse_bytes(hi), reverse_bytes(lo)});
      @(negedge clk_74a);
      bridge_wr = 1'b1;
      bridge_addr = word_addr(e, 1'b0);
      bridge_wr_data = lo;
      @(negedge clk_74a);
      bridge_addr = word_addr(e, 1'b1);
      bridge_wr_data = hi;
    end
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  // manager model, load side
  task automatic run_load_model();
    do @(negedge clk_74a); while (!ss_load);
    ss_busy = 1'b1;
    for (int e = 0; e < load_entries; e++) begin
      ss_req = 1'b1;
      do @(negedge clk_74a); while (!ss_ack);
      check_value("ss_dout", load_expect.pop_front(), ss_dout);
    end
    ss_req = 1'b0;
    ss_busy = 1'b0;
  endtask

  // host handshake on a start edge
  a_start_seq: assert property (@(posedge clk_74a) disable iff (!rst_n)
    $rose(savestate_start) |=> (ss_save && savestate_start_ack)
      ##1 (!ss_save && !savestate_start_ack && savestate_start_busy))
    else begin
      $display("save start did not give ack, ss_save and busy on the expected cycles");
      stop_on_error();
    end

  a_start_ok: assert property (@(posedge clk_74a) disable iff (!rst_n)
    savestate_start_busy && ss_req |=> savestate_start_ok && !savestate_start_busy)
    else begin
      $display("start ok did not rise after the first ss_req");
      stop_on_error();
    end

  a_save_single: assert property (@(posedge clk_74a) disable iff (!rst_n)
    ss_save |=> !ss_save)
    else begin
      $display("ss_save stayed high for more than one cycle");
      stop_on_error();
    end

  // save acks only right after a served read
  a_save_ack: assert property (@(posedge clk_74a) disable iff (!rst_n)
    in_save && ss_ack |-> $past(bridge_rd_valid))
    else begin
      $display("ss_ack during save without a completed read the cycle before");
      stop_on_error();
    end

  // data is always queued here, so two cycles from req to ack
  a_load_ack: assert property (@(posedge clk_74a) disable iff (!rst_n)
    in_load && ss_req && ($rose(ss_req) || $fell(ss_ack))
      |-> !ss_ack ##1 !ss_ack ##1 ss_ack)
    else begin
      $display("load ss_ack did not come two cycles after ss_req");
      stop_on_error();
    end

  a_load_end: assert property (@(posedge clk_74a) disable iff (!rst_n)
    $rose(savestate_load) |=> (savestate_load_ack && !savestate_start_ok)
      ##1 (!savestate_load_ack && savestate_load_busy)
      ##1 (!savestate_load_busy && savestate_load_ok))
    else begin
      $display("load completion did not run ack, busy, ok on consecutive cycles");
      stop_on_error();
    end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_74a);
    $display("watchdog expired before the tests finished");
    stop_on_error();
  end

  initial begin
    int acks_before;
    bridge_wr = 1'b0;
    bridge_rd = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    savestate_load = 1'b0;
    savestate_start = 1'b0;
    ss_din = '0;
    ss_req = 1'b0;
    ss_busy = 1'b0;
    do @(negedge clk_74a); while (!rst_n);

    check_low("ss_save", ss_save);
    check_low("ss_load", ss_load);
    check_low("ss_ack", ss_ack);
    check_low("bridge_rd_valid", bridge_rd_valid);
    check_low("savestate_load_ack", savestate_load_ack);
    check_low("savestate_load_busy", savestate_load_busy);
    check_low("savestate_load_ok", savestate_load_ok);
    check_low("savestate_start_ack", savestate_start_ack);
    check_low("savestate_start_busy", savestate_start_busy);
    check_low("savestate_start_ok", savestate_start_ok);

    in_save = 1'b1;
    fork
      run_save_host();
      run_save_model();
    join
    repeat (3) @(negedge clk_74a);
    in_save = 1'b0;
    check_count("ss_ack count after save", save_count, ack_count);

    acks_before = ack_count;
    in_load = 1'b1;
    fork
      run_load_host();
      run_load_model();
    join
    repeat (3) @(negedge clk_74a);
    in_load = 1'b0;
    check_count("ss_ack count after load", load_entries, ack_count - acks_before);
    check_count("ss_load pulses", 1, load_pulses);

    // start ok from the save must be cleared by the load edge
    check_value("savestate_start_ok", 64'(1), 64'(savestate_start_ok));
    savestate_load = 1'b1;
    repeat (4) @(negedge clk_74a);
    savestate_load = 1'b0;
    check_value("savestate_load_ok", 64'(1), 64'(savestate_load_ok));
    check_low("savestate_start_ok", savestate_start_ok);
    repeat (2) @(negedge clk_74a);

    if (!failed) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int period = 10,
  parameter int reset_cycles = 8
) (
  output logic clk_74a,
  output logic rst_n
);

  initial begin
    clk_74a = 1'b0;
    forever #(period / 2) clk_74a = ~clk_74a;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk_74a);
    @(negedge clk_74a);
    rst_n = 1'b1;
  end

endmodule

//--- verilog/load_fifo.sv
module load_fifo
  import save_state_pkg::*;
#(
  parameter int fifo_addr_bits = 4
) (
  input  logic         clk_74a,
  input  logic         rst_n,
  input  logic         bridge_wr,
  input  bridge_addr_t bridge_addr,
  input  host_word_t   bridge_wr_data,
  input  logic         fifo_pop,
  output ss_word_t     fifo_word,
  output logic         fifo_empty
);

  localparam int depth = 1 << fifo_addr_bits;

  ss_word_t mem [depth];
  // extra msb tells full from empty
  logic [fifo_addr_bits:0] wr_ptr;
  logic [fifo_addr_bits:0] rd_ptr;
  host_word_t low_half;
  // low half parked, next write completes the entry
  logic have_low;
  logic wr_hit;
  logic wr_commit;
  logic fifo_full;

  // reverse the four bytes of one bridge word
  function automatic host_word_t swap_bytes(input host_word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // only the save-state window feeds the fifo
  assign wr_hit = bridge_wr && (bridge_addr[31:28] == bridge_region);
  assign wr_commit = wr_hit && have_low;

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full = (wr_ptr[fifo_addr_bits] != rd_ptr[fifo_addr_bits]) &&
                     (wr_ptr[fifo_addr_bits-1:0] == rd_ptr[fifo_addr_bits-1:0]);

  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      have_low <= 1'b0;
    end else begin
      // pairing toggles on every window write
      if (wr_hit) begin
        have_low <= !have_low;
      end
      if (wr_commit) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_74a) begin
    if (wr_hit && !have_low) begin
      low_half <= bridge_wr_data;
    end
    // first host word is the low half
    if (wr_commit) begin
      mem[wr_ptr[fifo_addr_bits-1:0]] <= {bridge_wr_data, low_half};
    end
    // halves stay in place, bytes flip inside each half
    if (fifo_pop) begin
      fifo_word <= {swap_bytes(mem[rd_ptr[fifo_addr_bits-1:0]][63:32]),
                    swap_bytes(mem[rd_ptr[fifo_addr_bits-1:0]][31:0])};
    end
  end

  // a write into a full fifo is a host error
  a_no_write_full: assert property (@(posedge clk_74a) disable iff (!rst_n)
    !(wr_commit && fifo_full));

  // sequencer only pops after seeing data
  a_no_pop_empty: assert property (@(posedge clk_74a) disable iff (!rst_n)
    !(fifo_pop && fifo_empty));

endmodule

//--- verilog/save_state_controller.sv
module save_state_controller
  import save_state_pkg::*;
#(
  parameter int fifo_addr_bits = 4
) (
  input  logic         clk_74a,
  input  logic         rst_n,
  input  logic         bridge_wr,
  input  logic         bridge_rd,
  input  bridge_addr_t bridge_addr,
  input  host_word_t   bridge_wr_data,
  output host_word_t   bridge_rd_data,
  output logic         bridge_rd_valid,
  input  logic         savestate_load,
  output logic         savestate_load_ack,
  output logic         savestate_load_busy,
  output logic         savestate_load_ok,
  input  logic         savestate_start,
  output logic         savestate_start_ack,
  output logic         savestate_start_busy,
  output logic         savestate_start_ok,
  output logic         ss_save,
  output logic         ss_load,
  input  ss_word_t     ss_din,
  output ss_word_t     ss_dout,
  input  logic         ss_req,
  output logic         ss_ack,
  input  logic         ss_busy
);

  logic fifo_empty;
  logic fifo_pop;
  logic save_capture;
  logic word_done;

  // host writes in, packed words out to the manager
  load_fifo #(
    .fifo_addr_bits(fifo_addr_bits)
  ) load_fifo0 (
    .clk_74a       (clk_74a),
    .rst_n         (rst_n),
    .bridge_wr     (bridge_wr),
    .bridge_addr   (bridge_addr),
    .bridge_wr_data(bridge_wr_data),
    .fifo_pop      (fifo_pop),
    .fifo_word     (ss_dout),
    .fifo_empty    (fifo_empty)
  );

  save_state_sequencer sequencer0 (
    .clk_74a             (clk_74a),
    .rst_n               (rst_n),
    .savestate_start     (savestate_start),
    .savestate_load      (savestate_load),
    .ss_req              (ss_req),
    .ss_busy             (ss_busy),
    .fifo_empty          (fifo_empty),
    .word_done           (word_done),
    .ss_save             (ss_save),
    .ss_load             (ss_load),
    .ss_ack              (ss_ack),
    .fifo_pop            (fifo_pop),
    .save_capture        (save_capture),
    .savestate_load_ack  (savestate_load_ack),
    .savestate_load_busy (savestate_load_busy),
    .savestate_load_ok   (savestate_load_ok),
    .savestate_start_ack (savestate_start_ack),
    .savestate_start_busy(savestate_start_busy),
    .savestate_start_ok  (savestate_start_ok)
  );

  // manager words out to host reads
  save_word_unloader unloader0 (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_rd      (bridge_rd),
    .bridge_addr    (bridge_addr),
    .ss_din         (ss_din),
    .save_capture   (save_capture),
    .bridge_rd_data (bridge_rd_data),
    .bridge_rd_valid(bridge_rd_valid),
    .word_done      (word_done)
  );

endmodule

//--- verilog/save_state_pkg.sv
package save_state_pkg;

  // bridge data path is 32 bits wide
  localparam int host_word_bits = 32;

  // manager moves two bridge words at a time
  localparam int ss_word_bits = 2 * host_word_bits;

  // address bits 27 to 3 select a 64-bit word
  localparam int word_index_bits = 25;

  typedef logic [host_word_bits-1:0] host_word_t;
  typedef logic [ss_word_bits-1:0] ss_word_t;
  typedef logic [31:0] bridge_addr_t;
  typedef logic [word_index_bits-1:0] word_index_t;

  // upper address nibble of the save-state window
  localparam logic [3:0] bridge_region = 4'h4;

  typedef enum logic [2:0] {
    // nothing running, watching for load data
    idle,
    // ss_save just pulsed
    save_announce,
    save_wait_first,
    // one word per ss_req until busy falls
    save_stream,
    load_stream,
    // manager finished, host has not confirmed yet
    load_wait_host,
    load_ack,
    load_done
  } seq_state_t;

endpackage

//--- verilog/save_state_sequencer.sv
module save_state_sequencer
  import save_state_pkg::*;
(
  input  logic clk_74a,
  input  logic rst_n,
  input  logic savestate_start,
  input  logic savestate_load,
  input  logic ss_req,
  input  logic ss_busy,
  input  logic fifo_empty,
  input  logic word_done,
  output logic ss_save,
  output logic ss_load,
  output logic ss_ack,
  output logic fifo_pop,
  output logic save_capture,
  output logic savestate_load_ack,
  output logic savestate_load_busy,
  output logic savestate_load_ok,
  output logic savestate_start_ack,
  output logic savestate_start_busy,
  output logic savestate_start_ok
);

  seq_state_t state;
  logic start_q;
  logic load_q;
  logic busy_q;
  logic start_edge;
  logic load_edge;
  logic busy_fall;
  // save word handed to the unloader, high half not served yet
  logic word_out;
  // load request arrived while the fifo was empty
  logic req_seen;
  // host load edge seen, handshake not finished
  logic load_pending;

  assign start_edge = savestate_start && !start_q;
  assign load_edge = savestate_load && !load_q;
  assign busy_fall = busy_q && !ss_busy;

  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      state <= idle;
      start_q <= 1'b0;
      load_q <= 1'b0;
      busy_q <= 1'b0;
      word_out <= 1'b0;
      req_seen <= 1'b0;
      load_pending <= 1'b0;
      ss_save <= 1'b0;
      ss_load <= 1'b0;
      ss_ack <= 1'b0;
      fifo_pop <= 1'b0;
      save_capture <= 1'b0;
      savestate_load_ack <= 1'b0;
      savestate_load_busy <= 1'b0;
      savestate_load_ok <= 1'b0;
      savestate_start_ack <= 1'b0;
      savestate_start_busy <= 1'b0;
      savestate_start_ok <= 1'b0;
    end else begin
      start_q <= savestate_start;
      load_q <= savestate_load;
      busy_q <= ss_busy;
      // strobes default low
      ss_save <= 1'b0;
      ss_load <= 1'b0;
      ss_ack <= 1'b0;
      fifo_pop <= 1'b0;
      save_capture <= 1'b0;

      // host confirms the load, may come before busy falls
      if (load_edge) begin
        load_pending <= 1'b1;
        savestate_load_ack <= 1'b1;
        savestate_load_ok <= 1'b0;
        savestate_start_ok <= 1'b0;
      end

      case (state)
        idle: begin
          // first packed word kicks off a load
          if (!fifo_empty) begin
            ss_load <= 1'b1;
            req_seen <= 1'b0;
            state <= load_stream;
          end
        end
        save_announce: begin
          savestate_start_ack <= 1'b0;
          savestate_start_busy <= 1'b1;
          state <= save_wait_first;
        end
        save_wait_first: begin
          if (ss_req) begin
            savestate_start_busy <= 1'b0;
            savestate_start_ok <= 1'b1;
            save_capture <= 1'b1;
            word_out <= 1'b1;
            state <= save_stream;
          end else if (busy_fall) begin
            savestate_start_busy <= 1'b0;
            state <= idle;
          end
        end
        save_stream: begin
          // host took the high half, release the manager
          if (word_done) begin
            word_out <= 1'b0;
            ss_ack <= 1'b1;
          end else if (ss_req && !word_out && !ss_ack) begin
            // skip the cycle of our own ack, req is still up then
            save_capture <= 1'b1;
            word_out <= 1'b1;
          end else if (busy_fall) begin
            state <= idle;
          end
        end
        load_stream: begin
          // fifo_word is out now, ack goes with it
          if (fifo_pop) begin
            ss_ack <= 1'b1;
          end else if (busy_fall) begin
            state <= load_wait_host;
          end else if ((ss_req || req_seen) && !ss_ack) begin
            if (fifo_empty) begin
              req_seen <= 1'b1;
            end else begin
              fifo_pop <= 1'b1;
              req_seen <= 1'b0;
            end
          end
        end
        load_wait_host: begin
          if (load_pending || load_edge) begin
            state <= load_ack;
          end
        end
        load_ack: begin
          savestate_load_ack <= 1'b0;
          savestate_load_busy <= 1'b1;
          state <= load_done;
        end
        load_done: begin
          savestate_load_busy <= 1'b0;
          savestate_load_ok <= 1'b1;
          load_pending <= 1'b0;
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase

      // save start wins over anything in flight
      if (start_edge) begin
        state <= save_announce;
        ss_save <= 1'b1;
        ss_load <= 1'b0;
        fifo_pop <= 1'b0;
        save_capture <= 1'b0;
        word_out <= 1'b0;
        savestate_start_ack <= 1'b1;
        savestate_start_ok <= 1'b0;
        savestate_load_ok <= 1'b0;
      end
    end
  end

  // manager must see each ack as a separate one-cycle pulse
  a_ack_single: assert property (@(posedge clk_74a) disable iff (!rst_n)
    ss_ack |=> !ss_ack);

  a_save_load_excl: assert property (@(posedge clk_74a) disable iff (!rst_n)
    !(ss_save && ss_load));

endmodule

//--- verilog/save_word_unloader.sv
module save_word_unloader
  import save_state_pkg::*;
(
  input  logic         clk_74a,
  input  logic         rst_n,
  input  logic         bridge_rd,
  input  bridge_addr_t bridge_addr,
  input  ss_word_t     ss_din,
  input  logic         save_capture,
  output host_word_t   bridge_rd_data,
  output logic         bridge_rd_valid,
  output logic         word_done
);

  ss_word_t cur_word;
  logic cur_held;
  // last word fully read, kept for repeated reads
  ss_word_t prev_word;
  word_index_t prev_index;
  logic prev_valid;
  logic rd_hit;
  word_index_t rd_index;
  logic rd_dup;
  // read waiting for the manager
  logic pend;
  word_index_t pend_index;
  logic pend_high;
  logic serve;
  word_index_t serve_index;
  logic serve_high;

  assign rd_hit = bridge_rd && (bridge_addr[31:28] == bridge_region);
  assign rd_index = bridge_addr[27:3];
  assign rd_dup = prev_valid && (rd_index == prev_index);

  // new read or parked read, once a word is held
  assign serve = cur_held && ((rd_hit && !rd_dup) || pend);
  assign serve_index = pend ? pend_index : rd_index;
  assign serve_high = pend ? pend_high : bridge_addr[2];

  always_ff @(posedge clk_74a) begin
    if (!rst_n) begin
      cur_held <= 1'b0;
      prev_valid <= 1'b0;
      pend <= 1'b0;
      bridge_rd_valid <= 1'b0;
      word_done <= 1'b0;
    end else begin
      bridge_rd_valid <= 1'b0;
      word_done <= 1'b0;
      if (rd_hit && rd_dup) begin
        bridge_rd_valid <= 1'b1;
      end else if (rd_hit && !cur_held) begin
        pend <= 1'b1;
      end
      if (serve) begin
        bridge_rd_valid <= 1'b1;
        pend <= 1'b0;
        // high half closes the word
        if (serve_high) begin
          cur_held <= 1'b0;
          prev_valid <= 1'b1;
          word_done <= 1'b1;
        end
      end
      if (save_capture) begin
        cur_held <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_74a) begin
    // repeat of the last word, answered from the copy
    if (rd_hit && rd_dup) begin
      bridge_rd_data <= bridge_addr[2] ? prev_word[63:32] : prev_word[31:0];
    end
    if (rd_hit && !rd_dup && !cur_held) begin
      pend_index <= rd_index;
      pend_high <= bridge_addr[2];
    end
    if (serve) begin
      bridge_rd_data <= serve_high ? cur_word[63:32] : cur_word[31:0];
      if (serve_high) begin
        prev_word <= cur_word;
        prev_index <= serve_index;
      end
    end
    if (save_capture) begin
      cur_word <= ss_din;
    end
  end

  // sequencer waits for word_done before the next capture
  a_no_capture_held: assert property (@(posedge clk_74a) disable iff (!rst_n)
    save_capture |-> !cur_held);

endmodule
